// File: verilog/legalizer_cfg_pkg.sv
// Bus, address and page constants for the transfer legalizer; import into RTL and bench
package legalizer_cfg_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    // Data bus width in bits
    localparam int unsigned DATA_WIDTH = 32;
    // Bytes per beat
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
    // Byte offset bits inside one beat
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);

    // Byte address width, also sizes the transfer length
    localparam int unsigned ADDR_WIDTH = 24;

    // --------------------------------------------------
    // Page geometry
    // --------------------------------------------------
    // 256 beats, but never more than 4 KiB
    localparam int unsigned PAGE_SIZE = (256 * STRB_WIDTH > 4096) ? 4096 : 256 * STRB_WIDTH;
    // Page offset bits
    localparam int unsigned PAGE_ADDR_WIDTH = $clog2(PAGE_SIZE);

    // AXI field widths
    localparam int unsigned LLEN_WIDTH = 3;
    localparam int unsigned BEAT_LEN_WIDTH = 8;
    localparam int unsigned SIZE_WIDTH = 3;
    localparam int unsigned ID_WIDTH = 4;

endpackage

// File: verilog/legalizer_types_pkg.sv
// Request and burst structs passed between legalizer blocks and on its top ports
package legalizer_types_pkg;

    import legalizer_cfg_pkg::*;

    // Byte address, also a byte length
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Byte count up to and including one full page
    typedef logic [PAGE_ADDR_WIDTH:0] page_len_t;

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------
    // Per-side burst options
    // Cap is STRB_WIDTH << max_llen bytes when reduce_len is set
    typedef struct packed {
        logic                  reduce_len;
        logic [LLEN_WIDTH-1:0] max_llen;
    } side_opt_t;

    // One 1D copy request
    typedef struct packed {
        addr_t               length;
        addr_t               src_addr;
        addr_t               dst_addr;
        side_opt_t           src_opt;
        side_opt_t           dst_opt;
        logic                decouple_rw;
        logic [ID_WIDTH-1:0] axi_id;
        logic                last;
    } xfer_req_t;

    // --------------------------------------------------
    // Burst side
    // --------------------------------------------------
    // One AR or AW beat descriptor, incremental only
    typedef struct packed {
        logic [ID_WIDTH-1:0]       axi_id;
        addr_t                     addr;
        logic [BEAT_LEN_WIDTH-1:0] len;
        logic [SIZE_WIDTH-1:0]     size;
    } burst_t;

    // Write burst with end-of-request markers
    typedef struct packed {
        burst_t burst;
        // Final burst of this request
        logic   last;
        // Copied from the request's last flag
        logic   super_last;
    } w_burst_t;

endpackage

// File: verilog/burst_splitter.sv
// One side's burst splitter; holds the running transfer and emits page-legal bursts
`timescale 1ns/10ps

module burst_splitter
    import legalizer_cfg_pkg::*;
    import legalizer_types_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    // New transfer from the top level
    input  logic      load_i,
    input  addr_t     load_addr_i,
    input  addr_t     load_len_i,
    input  side_opt_t opt_i,
    // Step enable and allowed bytes from the coupler
    input  logic      advance_i,
    input  page_len_t bytes_possible_i,
    // Results back to the coupler
    output page_len_t bytes_to_pb_o,
    output logic      final_o,
    output logic      busy_o,
    // Burst of the current step
    output burst_t    burst_o,
    output addr_t     remaining_o
);

    // Running transfer
    addr_t     addr_q;
    addr_t     len_q;
    logic      valid_q;
    side_opt_t opt_q;

    // Boundary distances
    page_len_t page_dist;
    page_len_t cap_bytes;
    page_len_t cap_mask;
    page_len_t cap_dist;
    addr_t     cap_wide;

    // Current burst size
    page_len_t num_bytes;
    page_len_t beat_span;
    page_len_t last_byte;

    // --------------------------------------------------
    // Boundary distance
    // --------------------------------------------------
    // Bytes left up to the next page
    assign page_dist = page_len_t'(PAGE_SIZE) - page_len_t'(addr_q[PAGE_ADDR_WIDTH-1:0]);

    // Cap in bytes, limited to one page
    assign cap_wide  = addr_t'(STRB_WIDTH) << opt_q.max_llen;
    assign cap_bytes = (cap_wide > addr_t'(PAGE_SIZE)) ?
                       page_len_t'(PAGE_SIZE) : cap_wide[PAGE_ADDR_WIDTH:0];
    assign cap_mask  = cap_bytes - 1'b1;

    // Bytes left up to the next cap-aligned boundary
    assign cap_dist = cap_bytes -
                      page_len_t'(addr_q[PAGE_ADDR_WIDTH-1:0] & cap_mask[PAGE_ADDR_WIDTH-1:0]);

    always_comb begin
        bytes_to_pb_o = page_dist;
        // Take the nearer boundary when the cap is active
        if (opt_q.reduce_len && (cap_dist < page_dist)) begin
            bytes_to_pb_o = cap_dist;
        end
    end

    // --------------------------------------------------
    // Burst generation
    // --------------------------------------------------
    // Remainder fits; also true when idle with zero length
    assign final_o = (len_q <= addr_t'(bytes_possible_i));

    // Whole remainder or as much as allowed
    assign num_bytes = final_o ? len_q[PAGE_ADDR_WIDTH:0] : bytes_possible_i;

    // Beat count covers the start offset too
    assign beat_span = num_bytes + page_len_t'(addr_q[OFFSET_WIDTH-1:0]);
    assign last_byte = beat_span - 1'b1;

    always_comb begin
        // ID added at top level
        burst_o.axi_id = '0;
        // Beat aligned start
        burst_o.addr   = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        burst_o.len    = last_byte[OFFSET_WIDTH +: BEAT_LEN_WIDTH];
        // Always full bus width
        burst_o.size   = SIZE_WIDTH'(OFFSET_WIDTH);
    end

    assign busy_o      = valid_q;
    assign remaining_o = len_q;

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            addr_q  <= '0;
            len_q   <= '0;
            valid_q <= 1'b0;
            opt_q   <= '0;
        end else if (load_i) begin
            // Load wins over a final step in the same cycle
            addr_q  <= load_addr_i;
            len_q   <= load_len_i;
            valid_q <= (load_len_i != '0);
            opt_q   <= opt_i;
        end else if (advance_i && valid_q) begin
            if (final_o) begin
                // Last burst out, back to idle
                len_q   <= '0;
                valid_q <= 1'b0;
            end else begin
                len_q  <= len_q - addr_t'(bytes_possible_i);
                addr_q <= addr_q + addr_t'(bytes_possible_i);
            end
        end
    end

    // Active transfer always has bytes left
    a_valid_len : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_q |-> (len_q != '0));

endmodule

// File: verilog/rw_coupler.sv
// Read/write coupler; joins both splitters' distances and runs flow control and acceptance
`timescale 1ns/10ps

module rw_coupler
    import legalizer_types_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Request side
    input  logic      decouple_i,
    input  logic      req_valid_i,
    // Burst readies
    input  logic      r_ready_i,
    input  logic      w_ready_i,
    // Splitter status
    input  logic      r_busy_i,
    input  logic      w_busy_i,
    input  logic      r_final_i,
    input  logic      w_final_i,
    input  page_len_t r_to_pb_i,
    input  page_len_t w_to_pb_i,
    // Splitter control
    output page_len_t r_possible_o,
    output page_len_t w_possible_o,
    output logic      r_advance_o,
    output logic      w_advance_o,
    // Burst valids
    output logic      r_valid_o,
    output logic      w_valid_o,
    // Request acceptance
    output logic      load_o,
    output logic      ready_o
);

    // Mode of the running request
    logic      decouple_q;
    // Nearer of both boundaries
    page_len_t c_to_pb;

    assign c_to_pb = (r_to_pb_i > w_to_pb_i) ? w_to_pb_i : r_to_pb_i;

    // --------------------------------------------------
    // Boundary selection and flow control
    // --------------------------------------------------
    always_comb begin
        // Coupled by default
        r_possible_o = c_to_pb;
        w_possible_o = c_to_pb;
        r_advance_o  = r_ready_i & w_ready_i;
        w_advance_o  = r_ready_i & w_ready_i;
        if (decouple_q) begin
            // Each side on its own
            r_possible_o = r_to_pb_i;
            w_possible_o = w_to_pb_i;
            r_advance_o  = r_ready_i;
            w_advance_o  = w_ready_i;
        end
    end

    // Valid already qualified by ready
    assign r_valid_o = r_busy_i & r_advance_o;
    assign w_valid_o = w_busy_i & w_advance_o;

    // --------------------------------------------------
    // Request acceptance
    // --------------------------------------------------
    // Both sides on their last step and both able to take it
    assign ready_o = r_final_i & w_final_i & r_ready_i & w_ready_i;
    assign load_o  = ready_o & req_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            decouple_q <= 1'b0;
        end else if (load_o) begin
            decouple_q <= decouple_i;
        end
    end

    // Coupled bursts always leave in pairs
    a_coupled_pairs : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !decouple_q |-> (r_valid_o == w_valid_o));

endmodule

// File: verilog/transfer_legalizer.sv
// Top level of the transfer legalizer; splits one 1D request into read and write bursts
`timescale 1ns/10ps

module transfer_legalizer
    import legalizer_cfg_pkg::*;
    import legalizer_types_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    // 1D request
    input  xfer_req_t req_i,
    input  logic      valid_i,
    output logic      ready_o,
    // Read bursts
    output burst_t    r_burst_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,
    // Write bursts
    output w_burst_t  w_burst_o,
    output logic      w_valid_o,
    input  logic      w_ready_i,
    // Side activity
    output logic      r_busy_o,
    output logic      w_busy_o
);

    // Request fields kept for the bursts
    logic [ID_WIDTH-1:0] id_q;
    logic                last_q;

    // Coupler to splitters
    logic      load;
    logic      r_advance;
    logic      w_advance;
    page_len_t r_possible;
    page_len_t w_possible;

    // Splitters to coupler
    page_len_t r_to_pb;
    page_len_t w_to_pb;
    logic      r_final;
    logic      w_final;
    logic      r_busy;
    logic      w_busy;

    // Raw bursts and remainders
    burst_t    r_burst;
    burst_t    w_burst;
    addr_t     r_remaining;
    addr_t     w_remaining;

    // --------------------------------------------------
    // Splitters
    // --------------------------------------------------
    burst_splitter u_read_splitter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .load_i           (load),
        .load_addr_i      (req_i.src_addr),
        .load_len_i       (req_i.length),
        .opt_i            (req_i.src_opt),
        .advance_i        (r_advance),
        .bytes_possible_i (r_possible),
        .bytes_to_pb_o    (r_to_pb),
        .final_o          (r_final),
        .busy_o           (r_busy),
        .burst_o          (r_burst),
        .remaining_o      (r_remaining)
    );

    burst_splitter u_write_splitter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .load_i           (load),
        .load_addr_i      (req_i.dst_addr),
        .load_len_i       (req_i.length),
        .opt_i            (req_i.dst_opt),
        .advance_i        (w_advance),
        .bytes_possible_i (w_possible),
        .bytes_to_pb_o    (w_to_pb),
        .final_o          (w_final),
        .busy_o           (w_busy),
        .burst_o          (w_burst),
        .remaining_o      (w_remaining)
    );

    // Coupled or decoupled stepping
    rw_coupler u_coupler (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .decouple_i   (req_i.decouple_rw),
        .req_valid_i  (valid_i),
        .r_ready_i    (r_ready_i),
        .w_ready_i    (w_ready_i),
        .r_busy_i     (r_busy),
        .w_busy_i     (w_busy),
        .r_final_i    (r_final),
        .w_final_i    (w_final),
        .r_to_pb_i    (r_to_pb),
        .w_to_pb_i    (w_to_pb),
        .r_possible_o (r_possible),
        .w_possible_o (w_possible),
        .r_advance_o  (r_advance),
        .w_advance_o  (w_advance),
        .r_valid_o    (r_valid_o),
        .w_valid_o    (w_valid_o),
        .load_o       (load),
        .ready_o      (ready_o)
    );

    // --------------------------------------------------
    // Request fields and outputs
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (load) begin
            id_q   <= req_i.axi_id;
            last_q <= req_i.last;
        end
    end

    always_comb begin
        r_burst_o        = r_burst;
        r_burst_o.axi_id = id_q;
    end

    always_comb begin
        w_burst_o.burst        = w_burst;
        w_burst_o.burst.axi_id = id_q;
        // Remainder fits, so this ends the request
        w_burst_o.last         = w_final;
        w_burst_o.super_last   = last_q;
    end

    assign r_busy_o = r_busy;
    assign w_busy_o = w_busy;

    // An idle side holds no bytes, so no transfer is cut short
    a_idle_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (r_busy || (r_remaining == '0)) && (w_busy || (w_remaining == '0)));

endmodule

// File: bench/legalizer_ref.svh
// Reference split of one request into expected read and write bursts; included by the bench
`ifndef LEGALIZER_REF_SVH
`define LEGALIZER_REF_SVH

// One expected burst, same layout for both sides
typedef struct packed {
    addr_t                     addr;
    logic [BEAT_LEN_WIDTH-1:0] len;
    logic [SIZE_WIDTH-1:0]     size;
    logic [ID_WIDTH-1:0]       id;
    logic                      last;
    logic                      super_last;
} exp_burst_t;

// Expected bursts in issue order
exp_burst_t exp_r_q[$];
exp_burst_t exp_w_q[$];

// Bytes up to the next page, or to the next cap multiple if nearer
function automatic int unsigned boundary_dist(input int unsigned addr, input side_opt_t opt);
    int unsigned to_page;
    int unsigned cap;
    int unsigned to_cap;
    to_page = PAGE_SIZE - (addr % PAGE_SIZE);
    cap     = STRB_WIDTH << opt.max_llen;
    if (cap > PAGE_SIZE) begin
        cap = PAGE_SIZE;
    end
    to_cap = cap - (addr % cap);
    if (opt.reduce_len && (to_cap < to_page)) begin
        to_page = to_cap;
    end
    return to_page;
endfunction

function automatic exp_burst_t make_burst(input int unsigned addr, input int unsigned nbytes,
                                          input xfer_req_t req, input logic is_last);
    exp_burst_t b;
    b.addr       = addr_t'(addr & ~(STRB_WIDTH - 1));
    // Beat count includes the offset into the first beat
    b.len        = BEAT_LEN_WIDTH'((nbytes + (addr % STRB_WIDTH) - 1) / STRB_WIDTH);
    // Full bus width beats
    b.size       = SIZE_WIDTH'($clog2(STRB_WIDTH));
    b.id         = req.axi_id;
    b.last       = is_last;
    b.super_last = req.last;
    return b;
endfunction

// Walk both sides step by step and queue every burst
function automatic void predict_request(input xfer_req_t req);
    int unsigned r_addr;
    int unsigned w_addr;
    int unsigned r_left;
    int unsigned w_left;
    int unsigned r_step;
    int unsigned w_step;
    r_addr = 32'(req.src_addr);
    w_addr = 32'(req.dst_addr);
    r_left = 32'(req.length);
    w_left = 32'(req.length);
    while ((r_left != 0) || (w_left != 0)) begin
        r_step = boundary_dist(r_addr, req.src_opt);
        w_step = boundary_dist(w_addr, req.dst_opt);
        // Coupled: both cut at the nearer boundary
        if (!req.decouple_rw) begin
            r_step = (r_step < w_step) ? r_step : w_step;
            w_step = r_step;
        end
        if (r_left != 0) begin
            r_step = (r_left < r_step) ? r_left : r_step;
            exp_r_q.push_back(make_burst(r_addr, r_step, req, r_left == r_step));
            r_addr += r_step;
            r_left -= r_step;
        end
        if (w_left != 0) begin
            w_step = (w_left < w_step) ? w_left : w_step;
            exp_w_q.push_back(make_burst(w_addr, w_step, req, w_left == w_step));
            w_addr += w_step;
            w_left -= w_step;
        end
    end
endfunction

`endif

// File: bench/legalizer_tb.sv
// Testbench for the transfer legalizer; directed and random requests against a reference split
`timescale 1ns/10ps

module legalizer_tb
    import legalizer_cfg_pkg::*;
    import legalizer_types_pkg::*;
();

    localparam int unsigned NUM_DIRECTED   = 7;
    localparam int unsigned NUM_RANDOM     = 40;
    // Cycle budget per request
    localparam int unsigned TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 600;

    // Side options for directed requests
    localparam side_opt_t NO_CAP  = '{reduce_len: 1'b0, max_llen: 3'd0};
    localparam side_opt_t CAP_4   = '{reduce_len: 1'b1, max_llen: 3'd0};
    localparam side_opt_t CAP_32  = '{reduce_len: 1'b1, max_llen: 3'd3};
    localparam side_opt_t CAP_128 = '{reduce_len: 1'b1, max_llen: 3'd5};
    localparam side_opt_t CAP_256 = '{reduce_len: 1'b1, max_llen: 3'd6};
    localparam side_opt_t CAP_512 = '{reduce_len: 1'b1, max_llen: 3'd7};

    logic        clk_i;
    logic        rst_n_i;
    xfer_req_t   req_i;
    logic        valid_i;
    logic        ready_o;
    burst_t      r_burst_o;
    logic        r_valid_o;
    logic        r_ready_i;
    w_burst_t    w_burst_o;
    logic        w_valid_o;
    logic        w_ready_i;
    logic        r_busy_o;
    logic        w_busy_o;

    int unsigned mismatch_count;
    int unsigned flow_count;
    // Back-pressure on or off
    logic        random_ready;
    // Mode of the request in flight
    logic        run_coupled;
    // Side must be idle on the next edge
    logic        r_idle_exp;
    logic        w_idle_exp;

    `include "legalizer_ref.svh"

    transfer_legalizer transfer_legalizer_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .r_burst_o (r_burst_o),
        .r_valid_o (r_valid_o),
        .r_ready_i (r_ready_i),
        .w_burst_o (w_burst_o),
        .w_valid_o (w_valid_o),
        .w_ready_i (w_ready_i),
        .r_busy_o  (r_busy_o),
        .w_busy_o  (w_busy_o)
    );

    always #50 clk_i = ~clk_i;

    // Readies drop at random only in back-pressure phases
    always @(posedge clk_i) begin
        r_ready_i <= !random_ready || (($urandom % 4) != 0);
        w_ready_i <= !random_ready || (($urandom % 4) != 0);
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        mismatch_count++;
        $display("mismatch %s: got %h expected %h", name, got, want);
    endtask

    task automatic report_error(input string msg);
        flow_count++;
        $display("Error: %s", msg);
    endtask

    task automatic compare_burst(input string port, input logic has_last,
                                 input exp_burst_t act, input exp_burst_t want);
        if (act.addr !== want.addr) begin
            report_mismatch({port, ".addr"}, 32'(act.addr), 32'(want.addr));
        end
        if (act.len !== want.len) begin
            report_mismatch({port, ".len"}, 32'(act.len), 32'(want.len));
        end
        if (act.size !== want.size) begin
            report_mismatch({port, ".size"}, 32'(act.size), 32'(want.size));
        end
        if (act.id !== want.id) begin
            report_mismatch({port, ".axi_id"}, 32'(act.id), 32'(want.id));
        end
        if (has_last && (act.last !== want.last)) begin
            report_mismatch({port, ".last"}, 32'(act.last), 32'(want.last));
        end
        if (has_last && (act.super_last !== want.super_last)) begin
            report_mismatch({port, ".super_last"}, 32'(act.super_last), 32'(want.super_last));
        end
    endtask

    function automatic xfer_req_t make_request(input addr_t len, input addr_t src,
            input addr_t dst, input side_opt_t src_opt, input side_opt_t dst_opt,
            input logic decouple);
        xfer_req_t req;
        req.length      = len;
        req.src_addr    = src;
        req.dst_addr    = dst;
        req.src_opt     = src_opt;
        req.dst_opt     = dst_opt;
        req.decouple_rw = decouple;
        req.axi_id      = ID_WIDTH'($urandom);
        req.last        = 1'($urandom);
        return req;
    endfunction

    function automatic xfer_req_t random_request();
        return make_request(addr_t'(1 + ($urandom % 1200)), addr_t'($urandom),
                            addr_t'($urandom), side_opt_t'($urandom),
                            side_opt_t'($urandom), 1'($urandom));
    endfunction

    // Hold one request until the DUT takes it; returns on the accepting edge
    task automatic send_request(input xfer_req_t req);
        req_i   <= req;
        valid_i <= 1'b1;
        do begin
            @(posedge clk_i);
        end while (!ready_o);
    endtask

    // --------------------------------------------------
    // Compare against the reference queues
    // --------------------------------------------------
    always @(posedge clk_i) begin
        exp_burst_t act;
        if (rst_n_i) begin
            if (r_idle_exp && r_busy_o) begin
                report_error("read side still busy after its final burst");
            end
            if (w_idle_exp && w_busy_o) begin
                report_error("write side still busy after its final burst");
            end
            if (run_coupled && (r_valid_o !== w_valid_o)) begin
                report_error("read and write bursts not paired in coupled mode");
            end
            // Valid is already qualified by its ready
            if (r_valid_o && !r_ready_i) begin
                report_error("read burst issued while its ready was low");
            end
            if (w_valid_o && !w_ready_i) begin
                report_error("write burst issued while its ready was low");
            end
            if (r_valid_o && (exp_r_q.size() == 0)) begin
                report_error("read burst issued with no read burst expected");
            end else if (r_valid_o) begin
                act = '{r_burst_o.addr, r_burst_o.len, r_burst_o.size, r_burst_o.axi_id,
                        1'b0, 1'b0};
                compare_burst("r_burst_o", 1'b0, act, exp_r_q.pop_front());
            end
            if (w_valid_o && (exp_w_q.size() == 0)) begin
                report_error("write burst issued with no write burst expected");
            end else if (w_valid_o) begin
                act = '{w_burst_o.burst.addr, w_burst_o.burst.len, w_burst_o.burst.size,
                        w_burst_o.burst.axi_id, w_burst_o.last, w_burst_o.super_last};
                compare_burst("w_burst_o", 1'b1, act, exp_w_q.pop_front());
            end
            // New request queued behind the old one's last bursts
            if (valid_i && ready_o) begin
                predict_request(req_i);
                run_coupled = !req_i.decouple_rw;
            end
            r_idle_exp = (exp_r_q.size() == 0);
            w_idle_exp = (exp_w_q.size() == 0);
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h252f_89a4));
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        req_i          = '0;
        valid_i        = 1'b0;
        r_ready_i      = 1'b0;
        w_ready_i      = 1'b0;
        random_ready   = 1'b0;
        run_coupled    = 1'b0;
        r_idle_exp     = 1'b1;
        w_idle_exp     = 1'b1;
        mismatch_count = 0;
        flow_count     = 0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Inside one page
        send_request(make_request(24'd40, 24'h00_1003, 24'h00_2011, NO_CAP, NO_CAP, 1'b0));
        // Page crossings, each side alone and then coupled
        send_request(make_request(24'd3000, 24'h00_03f0, 24'h01_0100, NO_CAP, NO_CAP, 1'b1));
        send_request(make_request(24'd3000, 24'h02_0a00, 24'h03_0000, NO_CAP, NO_CAP, 1'b0));
        // Burst caps
        send_request(make_request(24'd700, 24'h00_03e6, 24'h02_0050, CAP_32, CAP_128, 1'b1));
        send_request(make_request(24'd1500, 24'h04_0301, 24'h05_07fe, CAP_512, CAP_4, 1'b0));

        // Back-pressure from here on
        random_ready <= 1'b1;
        send_request(make_request(24'd2500, 24'h06_0123, 24'h07_03ff, NO_CAP, NO_CAP, 1'b0));
        send_request(make_request(24'd2000, 24'h08_0002, 24'h09_0301, CAP_256, NO_CAP, 1'b1));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_request(random_request());
        end
        valid_i <= 1'b0;

        // Drain the last request
        @(posedge clk_i);
        while (r_busy_o || w_busy_o) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        if ((exp_r_q.size() != 0) || (exp_w_q.size() != 0)) begin
            report_error("expected bursts never issued");
        end

        $display("Closing report: %0d mismatches, %0d other errors", mismatch_count, flow_count);
        if ((mismatch_count == 0) && (flow_count == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+bench
verilog/legalizer_cfg_pkg.sv
verilog/legalizer_types_pkg.sv
verilog/burst_splitter.sv
verilog/rw_coupler.sv
verilog/transfer_legalizer.sv
bench/legalizer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the legalizer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module legalizer_tb \
    -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vlegalizer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
